// File: source/fifo_demo_pkg.sv
`default_nettype none

package fifo_demo_pkg;

    localparam int data_width  = 4;
    localparam int fifo_depth  = 8;
    localparam int digit_count = 8;
    localparam int scan_div    = 4;

    typedef logic [data_width - 1:0] data_t;

    // Active high, segment a in bit 7 down to h in bit 0
    typedef logic [7:0] segments_t;

    localparam segments_t glyph_valid = 8'b1000_0000;
    localparam segments_t glyph_ready = 8'b0000_0010;
    localparam segments_t glyph_blank = 8'b0000_0000;

    // One side of a valid/ready link
    typedef struct packed {
        logic  valid;
        logic  ready;
        data_t data;
    } handshake_t;

    typedef struct packed {
        logic  up_ready;
        logic  down_valid;
        data_t up_data;
        data_t down_data;
    } status_leds_t;

    typedef segments_t [digit_count - 1:0] digit_patterns_t;

    // ----------------------------------------
    // Hex digit decoder

    function automatic segments_t hex_segments(data_t value);
        case (value)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/pattern_source.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_source
    import fifo_demo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       request,
    input  logic       accepted,
    output handshake_t offer
);

    // ----------------------------------------
    // Permutation of 0 to 15, offered in table order

    localparam data_t pattern_table [2 ** data_width] = '{
        4'h2, 4'h6, 4'hd, 4'hb,
        4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha,
        4'hf, 4'h5, 4'h8, 4'h3
    };

    logic [data_width - 1:0] index;

    // ----------------------------------------
    // Index moves only on an accepted transfer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (accepted) begin
            // Wraps back to entry 0 after the last one
            index <= index + 1'b1;
        end
    end

    // ----------------------------------------
    // Offer to the consumer

    always_comb begin
        offer.valid = request;
        // Filled in by whoever consumes the offer
        offer.ready = 1'b0;
        offer.data  = pattern_table[index];
    end

    // Index never moves without a request behind it
    assert property (@(posedge clk) disable iff (!rst_n)
        !request |=> $stable(index));

endmodule

`default_nettype wire

// File: source/ff_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ff_fifo
    import fifo_demo_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  up_valid,
    input  data_t up_data,
    output logic  up_ready,

    output logic  down_valid,
    output data_t down_data,
    input  logic  down_ready
);

    data_t storage [fifo_depth];

    logic [$clog2(fifo_depth) - 1:0] wr_ptr;
    logic [$clog2(fifo_depth) - 1:0] rd_ptr;
    logic [$clog2(fifo_depth + 1) - 1:0] count;

    logic push;
    logic pop;

    // ----------------------------------------
    // Handshake status from occupancy

    assign up_ready   = (count != fifo_depth);
    assign down_valid = (count != 0);

    assign push = up_valid && up_ready;
    assign pop  = down_valid && down_ready;

    // Head entry straight out of storage
    assign down_data = storage[rd_ptr];

    // ----------------------------------------
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= up_data;
        end
    end

    // ----------------------------------------
    // Pointers and count

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == fifo_depth - 1)
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end

            if (pop) begin
                if (rd_ptr == fifo_depth - 1)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end

            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Assertions

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= fifo_depth);

    // No write slot taken while full
    assert property (@(posedge clk) disable iff (!rst_n)
        (up_valid && count == fifo_depth) |=> $stable(wr_ptr));

    // Head held while the consumer stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        (down_valid && !down_ready) |=> (down_valid && $stable(down_data)));

endmodule

`default_nettype wire

// File: source/display_composer.sv
`timescale 1ns/1ps
`default_nettype none

module display_composer
    import fifo_demo_pkg::*;
(
    input  handshake_t      up,
    input  handshake_t      down,
    output digit_patterns_t patterns
);

    // ----------------------------------------
    // Status glyph, top bar for valid and middle bar for ready

    function automatic segments_t status_glyph(logic valid, logic ready);
        segments_t glyph;

        glyph = glyph_blank;
        if (valid)
            glyph = glyph | glyph_valid;
        if (ready)
            glyph = glyph | glyph_ready;
        return glyph;
    endfunction

    // ----------------------------------------
    // Digit map, index 0 is the rightmost digit

    always_comb begin
        for (int i = 0; i < digit_count; i++) begin
            patterns[i] = glyph_blank;
        end

        // Value being offered upstream
        patterns[3] = hex_segments(up.data);

        patterns[2] = status_glyph(up.valid, up.ready);
        patterns[1] = status_glyph(down.valid, down.ready);

        // Head of the FIFO, dark when empty
        if (down.valid)
            patterns[0] = hex_segments(down.data);
        else
            patterns[0] = glyph_blank;
    end

endmodule

`default_nettype wire

// File: source/segment_scan.sv
`timescale 1ns/1ps
`default_nettype none

module segment_scan
    import fifo_demo_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  digit_patterns_t          patterns,
    output segments_t                abcdefgh,
    output logic [digit_count - 1:0] digit
);

    logic [$clog2(scan_div) - 1:0] div_cnt;
    logic                          step;

    // ----------------------------------------
    // Scan prescaler

    assign step = (div_cnt == scan_div - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (step) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // One-hot digit rotation

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= digit_count'(1);
        end else if (step) begin
            // Rotate left, top digit wraps to position 0
            digit <= {digit[digit_count - 2:0], digit[digit_count - 1]};
        end
    end

    // ----------------------------------------
    // Segment select

    always_comb begin
        abcdefgh = glyph_blank;
        for (int i = 0; i < digit_count; i++) begin
            if (digit[i])
                abcdefgh = abcdefgh | patterns[i];
        end
    end

    // ----------------------------------------
    // Assertions

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit));

endmodule

`default_nettype wire

// File: source/fifo_demo_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_demo_top
    import fifo_demo_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [1:0]               key,
    output status_leds_t             led,
    output segments_t                abcdefgh,
    output logic [digit_count - 1:0] digit
);

    handshake_t      offer;
    handshake_t      up;
    handshake_t      down;
    digit_patterns_t patterns;

    logic  fifo_up_ready;
    logic  fifo_down_valid;
    data_t fifo_down_data;

    // ----------------------------------------
    // Link assembly

    // key[1] pushes, key[0] pops
    assign up   = '{valid: offer.valid, ready: fifo_up_ready, data: offer.data};
    assign down = '{valid: fifo_down_valid, ready: key[0], data: fifo_down_data};

    assign led = '{
        up_ready:   up.ready,
        down_valid: down.valid,
        up_data:    up.data,
        down_data:  down.data
    };

    // ----------------------------------------
    // Blocks

    pattern_source u_source (
        .clk      (clk),
        .rst_n    (rst_n),
        .request  (key[1]),
        .accepted (up.valid && up.ready),
        .offer    (offer)
    );

    ff_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_valid   (up.valid),
        .up_data    (up.data),
        .up_ready   (fifo_up_ready),
        .down_valid (fifo_down_valid),
        .down_data  (fifo_down_data),
        .down_ready (down.ready)
    );

    display_composer u_composer (
        .up       (up),
        .down     (down),
        .patterns (patterns)
    );

    segment_scan u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .patterns (patterns),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

// File: bench/tb_fifo_demo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_demo
    import fifo_demo_pkg::*;
();

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [1:0]               key;
    status_leds_t             led;
    segments_t                abcdefgh;
    logic [digit_count - 1:0] digit;

    // ----------------------------------------
    // Reference model state

    localparam data_t ref_pattern [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // Conventional a-g shapes, a in bit 7
    localparam segments_t hex_glyph_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    data_t                    ref_queue [$];
    logic [3:0]               ref_index = '0;
    logic                     checking = 1'b0;
    logic                     random_phase = 1'b0;
    int unsigned              lcg_state = 85;
    logic [digit_count - 1:0] seen_digits = '0;
    int                       window_cycles = 0;
    int                       full_hits = 0;
    int                       empty_hits = 0;
    int                       both_hits = 0;

    fifo_demo_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Helpers

    function automatic int unsigned lcg_next(int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic segments_t status_bars(logic valid, logic ready);
        return (valid ? 8'h80 : 8'h00) | (ready ? 8'h02 : 8'h00);
    endfunction

    // Expected glyph for one digit position, rightmost is 0
    function automatic segments_t expected_glyph(int pos, status_leds_t l, logic [1:0] k);
        segments_t glyph;

        glyph = 8'h00;
        case (pos)
            3: glyph = hex_glyph_table[l.up_data];
            2: glyph = status_bars(k[1], l.up_ready);
            1: glyph = status_bars(l.down_valid, k[0]);
            0: glyph = l.down_valid ? hex_glyph_table[l.down_data] : 8'h00;
            default: glyph = 8'h00;
        endcase
        return glyph;
    endfunction

    task automatic report_failure(string text);
        $display("%s", text);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, int unsigned got, int unsigned exp);
        report_failure($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                 $time, name, got, exp));
    endtask

    task automatic compare_leds(status_leds_t got, status_leds_t exp, bit head_known);
        if (got.up_ready !== exp.up_ready)
            report_mismatch("led.up_ready", got.up_ready, exp.up_ready);
        if (got.down_valid !== exp.down_valid)
            report_mismatch("led.down_valid", got.down_valid, exp.down_valid);
        if (got.up_data !== exp.up_data)
            report_mismatch("led.up_data", got.up_data, exp.up_data);
        // Head is only defined while the FIFO holds something
        if (head_known && got.down_data !== exp.down_data)
            report_mismatch("led.down_data", got.down_data, exp.down_data);
    endtask

    task automatic compare_segments(string name, segments_t got, segments_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic compare_digit(logic [digit_count - 1:0] got, logic [digit_count - 1:0] exp);
        if (got !== exp)
            report_mismatch("digit", got, exp);
    endtask

    // Waits until full (up_ready low) or empty (down_valid low)
    task automatic wait_for_fifo(bit want_full, int limit);
        int n;

        n = 0;
        @(negedge clk);
        while (want_full ? led.up_ready : led.down_valid) begin
            if (n == limit)
                report_failure(want_full ? "timeout waiting for the FIFO to fill"
                                         : "timeout waiting for the FIFO to drain");
            n++;
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Checker, samples 1 ns before each rising edge

    always @(negedge clk) begin : check_cycle
        status_leds_t expected;
        bit           do_push;
        bit           do_pop;
        int           lit;

        if (checking) begin
            #1;
            expected.up_ready   = (ref_queue.size() != fifo_depth);
            expected.down_valid = (ref_queue.size() != 0);
            expected.up_data    = ref_pattern[ref_index];
            expected.down_data  = (ref_queue.size() != 0) ? ref_queue[0] : 4'h0;
            compare_leds(led, expected, ref_queue.size() != 0);

            if (digit == 0 || (digit & (digit - 1'b1)) != 0)
                report_failure($sformatf("digit select %b is not one-hot at %0t",
                                         digit, $time));
            lit = 0;
            for (int i = 0; i < digit_count; i++) begin
                if (digit[i])
                    lit = i;
            end
            compare_segments("abcdefgh", abcdefgh, expected_glyph(lit, led, key));

            // Every position must light up once per full scan
            seen_digits = seen_digits | digit;
            window_cycles++;
            if (window_cycles == digit_count * scan_div) begin
                if (seen_digits != '1)
                    report_failure("a digit position stayed dark over a full scan");
                seen_digits   = '0;
                window_cycles = 0;
            end

            do_push = key[1] && (ref_queue.size() != fifo_depth);
            do_pop  = key[0] && (ref_queue.size() != 0);

            // Push and pop requested together, at full, at empty and in between
            if (random_phase && key == 2'b11) begin
                if (ref_queue.size() == fifo_depth)
                    full_hits++;
                if (ref_queue.size() == 0)
                    empty_hits++;
                if (do_push && do_pop)
                    both_hits++;
            end

            if (do_pop)
                void'(ref_queue.pop_front());
            if (do_push) begin
                ref_queue.push_back(ref_pattern[ref_index]);
                ref_index = ref_index + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Stimulus

    initial begin
        rst_n = 1'b0;
        key   = 2'b00;
        repeat (5) @(posedge clk);
        rst_n    <= 1'b1;
        checking <= 1'b1;

        // Reset state
        @(negedge clk);
        compare_leds(led, '{up_ready: 1'b1, down_valid: 1'b0, up_data: 4'h2,
                            down_data: 4'h0}, 1'b0);
        compare_digit(digit, digit_count'(1));

        // Fill under back-pressure
        @(posedge clk);
        key <= 2'b10;
        wait_for_fifo(1'b1, 40);
        compare_leds(led, '{up_ready: 1'b0, down_valid: 1'b1, up_data: 4'h1,
                            down_data: 4'h2}, 1'b1);

        // Drain in push order
        @(posedge clk);
        key <= 2'b01;
        wait_for_fifo(1'b0, 40);
        compare_leds(led, '{up_ready: 1'b1, down_valid: 1'b0, up_data: 4'h1,
                            down_data: 4'h0}, 1'b0);

        // Random keys, pushes favoured first and pops after
        @(posedge clk);
        random_phase = 1'b1;
        for (int i = 0; i < 400; i++) begin
            lcg_state = lcg_next(lcg_state);
            if (i < 200)
                key <= {lcg_state[31:30] != 2'b00, lcg_state[29:28] == 2'b00};
            else
                key <= {lcg_state[31:30] == 2'b00, lcg_state[29:28] != 2'b00};
            @(posedge clk);
        end
        key <= 2'b00;
        random_phase = 1'b0;

        // Idle scans for the display check
        repeat (2 * digit_count * scan_div) @(posedge clk);

        if (full_hits == 0 || empty_hits == 0 || both_hits == 0) begin
            report_failure("random phase missed the full, empty or push-and-pop case");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: fifo_demo.f
source/fifo_demo_pkg.sv
source/pattern_source.sv
source/ff_fifo.sv
source/display_composer.sv
source/segment_scan.sv
source/fifo_demo_top.sv
bench/tb_fifo_demo.sv

// File: Bender.yml
package:
  name: fifo_demo

sources:
  # Package first, then the blocks, then the top level
  - files:
      - source/fifo_demo_pkg.sv
      - source/pattern_source.sv
      - source/ff_fifo.sv
      - source/display_composer.sv
      - source/segment_scan.sv
      - source/fifo_demo_top.sv

  # Simulation only
  - target: test
    files:
      - bench/tb_fifo_demo.sv
